// ==== build.f ====
common/uart_bridge_pkg.sv
uart_master/uart_tx_frame.sv
uart_master/uart_rx_frame.sv
uart_master/uart_cmd_master.sv
logic/cmd_dispatch.sv
logic/rsp_collect.sv
logic/uart_bridge_top.sv
testbench/uart_slave_model.sv
testbench/tb_uart_bridge.sv

// ==== testbench/tb_uart_bridge.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_uart_bridge;
  import uart_bridge_pkg::*;

  localparam int SEED        = 32'h223bc780;
  localparam int ADDR_W      = CMD_W - DATA_W - 1;
  localparam int RING        = 64;
  localparam int KIND_OK     = 0;
  localparam int KIND_PAR    = 1;  // parity corrupted, data not checked.
  localparam int KIND_TMO    = 2;  // no answer at all.
  localparam int N_WR        = 6;  // writes per channel in test 1.
  localparam int N_UNW       = 4;
  localparam int ROUNDS      = 2;
  localparam int HOLD_MIN    = 400;
  localparam int HOLD_SPAN   = 501;
  localparam int N_CMDS      = NUM_CH * (2 * N_WR + N_UNW + ROUNDS) + 5;
  localparam int CMD_WORST   = 2 * FRAME_BITS * CLKS_PER_BIT + GAP_CYCLES + RSP_TIMEOUT;
  localparam int WDOG_CYCLES = 2 * (N_CMDS * CMD_WORST + ROUNDS * (HOLD_MIN + HOLD_SPAN) + 20);

  logic                        clk;
  logic                        rst_n;
  logic                        cmd_vld;
  logic [CH_W-1:0]             cmd_ch;
  logic [CMD_W-1:0]            cmd_data;
  logic                        cmd_rdy;
  wire logic [NUM_CH-1:0]      uart_rx;
  logic [NUM_CH-1:0]           uart_tx;
  logic                        rsp_rdy;
  logic                        rsp_vld;
  logic [CH_W-1:0]             rsp_ch;
  logic [DATA_W-1:0]           rsp_data;
  logic                        rsp_err;
  logic [NUM_CH-1:0]           corrupt;
  logic [NUM_CH-1:0]           drop;
  wire logic [NUM_CH-1:0][7:0] slv_errs;

  integer            seed;
  int                cyc = 0;
  int                n_pass = 0;
  int                n_fail = 0;
  int                t_fail0;
  int                t_slv0;
  logic [DATA_W-1:0] shadow  [NUM_CH][128];  // what the host wrote.
  logic              written [NUM_CH][128];
  int                addrs   [NUM_CH][N_WR];
  int                exp_kind [NUM_CH][RING];
  logic [DATA_W-1:0] exp_data [NUM_CH][RING];
  int                exp_cyc  [NUM_CH][RING];
  int                exp_wr [NUM_CH];
  int                exp_rd [NUM_CH];

  uart_bridge_top u_uart_bridge_top (
    .clk      (clk),
    .rst_n    (rst_n),
    .cmd_vld  (cmd_vld),
    .cmd_ch   (cmd_ch),
    .cmd_data (cmd_data),
    .uart_rx  (uart_rx),
    .rsp_rdy  (rsp_rdy),
    .cmd_rdy  (cmd_rdy),
    .uart_tx  (uart_tx),
    .rsp_vld  (rsp_vld),
    .rsp_ch   (rsp_ch),
    .rsp_data (rsp_data),
    .rsp_err  (rsp_err)
  );

  for (genvar i = 0; i < NUM_CH; i++)
  begin : g_slave
    uart_slave_model #(
      .CH   (i),
      .SEED (SEED + i)
    ) u_slave (
      .clk        (clk),
      .rx         (uart_tx[i]),
      .corrupt    (corrupt[i]),
      .drop       (drop[i]),
      .tx         (uart_rx[i]),
      .frame_errs (slv_errs[i])
    );
  end

  initial
  begin
    clk = 1'b0;
    forever
      #5 clk = ~clk;
  end

  always @(posedge clk)
    cyc <= cyc + 1;

  initial
  begin
    repeat (WDOG_CYCLES) @(posedge clk);
    $display("watchdog: run timed out after %0d cycles", WDOG_CYCLES);
    $display("Result: FAILED");
    $finish;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // reference and checks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  function automatic logic [DATA_W-1:0] expected_read(input int ch, input int addr);
    if (written[ch][addr])
      return shadow[ch][addr];
    else
      return DATA_W'(addr) ^ 8'h5A;
  endfunction

  function automatic int pending_count();
    int n;
    n = 0;
    for (int c = 0; c < NUM_CH; c++)
      n += exp_wr[c] - exp_rd[c];
    return n;
  endfunction

  function automatic int slave_err_total();
    int n;
    n = 0;
    for (int c = 0; c < NUM_CH; c++)
      n += int'(slv_errs[c]);
    return n;
  endfunction

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    begin
      assert (got === exp)
        n_pass++;
      else
      begin
        $display("Mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
        n_fail++;
      end
    end
  endtask

  task automatic check_true(input logic cond, input string msg);
    begin
      assert (cond === 1'b1)
        n_pass++;
      else
      begin
        $display("%s (at %0t)", msg, $time);
        n_fail++;
      end
    end
  endtask

  task automatic check_response();
    int ch;
    int idx;
    begin
      ch = int'(rsp_ch);
      check_true(exp_wr[ch] != exp_rd[ch],
                 $sformatf("response on channel %0d with no read open", ch));
      if (exp_wr[ch] != exp_rd[ch])
      begin
        idx = exp_rd[ch] % RING;
        exp_rd[ch]++;
        if (exp_kind[ch][idx] == KIND_OK)
        begin
          check_eq("rsp_err", rsp_err, 0);
          check_eq("rsp_data", rsp_data, exp_data[ch][idx]);
        end
        else
        begin
          check_eq("rsp_err", rsp_err, 1);
          if (exp_kind[ch][idx] == KIND_TMO)
          begin
            check_eq("rsp_data", rsp_data, 0);
            check_true(cyc - exp_cyc[ch][idx] >= RSP_TIMEOUT, "timeout response came too early");
          end
        end
      end
    end
  endtask

  // outputs are registered, so the old values are read here.
  always @(posedge clk)
  begin
    if (rst_n && rsp_vld && rsp_rdy)
      check_response();
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // host side
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic issue_cmd(input int ch, input logic [CMD_W-1:0] word, output int acc_cyc);
    begin
      @(negedge clk);
      cmd_vld  = 1'b1;
      cmd_ch   = CH_W'(ch);
      cmd_data = word;
      #1;
      while (!cmd_rdy)
      begin
        @(negedge clk);
        #1;
      end
      acc_cyc = cyc;
      @(negedge clk);  // taken on the edge in between.
      cmd_vld = 1'b0;
    end
  endtask

  task automatic write_reg(input int ch, input int addr, input logic [DATA_W-1:0] data);
    int acc;
    begin
      shadow[ch][addr]  = data;
      written[ch][addr] = 1'b1;
      issue_cmd(ch, {1'b1, ADDR_W'(addr), data}, acc);
    end
  endtask

  task automatic read_reg(input int ch, input int addr, input int kind);
    int acc;
    int idx;
    begin
      issue_cmd(ch, {1'b0, ADDR_W'(addr), 8'h00}, acc);
      idx = exp_wr[ch] % RING;
      exp_kind[ch][idx] = kind;
      exp_data[ch][idx] = expected_read(ch, addr);
      exp_cyc[ch][idx]  = acc;
      exp_wr[ch]++;
    end
  endtask

  task automatic wait_drain();
    begin
      while (pending_count() != 0)
        @(negedge clk);
      repeat (4) @(negedge clk);  // room for a stray extra response.
    end
  endtask

  task automatic begin_test();
    begin
      t_fail0 = n_fail;
      t_slv0  = slave_err_total();
    end
  endtask

  task automatic report_test(input int num, input string name);
    begin
      check_true(slave_err_total() == t_slv0, "slave model received a malformed frame");
      if (n_fail == t_fail0)
        $display("test %0d %s: ok", num, name);
      else
        $display("test %0d %s: %0d failed checks", num, name, n_fail - t_fail0);
    end
  endtask

  initial
  begin
    int ch;
    int addr;
    int hold;
    seed     = SEED;
    rst_n    = 1'b0;
    cmd_vld  = 1'b0;
    cmd_ch   = '0;
    cmd_data = '0;
    rsp_rdy  = 1'b1;
    corrupt  = '0;
    drop     = '0;
    for (int c = 0; c < NUM_CH; c++)
    begin
      exp_wr[c] = 0;
      exp_rd[c] = 0;
      for (int a = 0; a < 128; a++)
        written[c][a] = 1'b0;
    end
    repeat (4) @(negedge clk);
    rst_n = 1'b1;

    begin_test();
    for (int c = 0; c < NUM_CH; c++)
    begin
      @(negedge clk);
      cmd_ch = CH_W'(c);
      #1;
      check_eq("cmd_rdy", cmd_rdy, 1);
    end
    check_eq("uart_tx", uart_tx, {NUM_CH{1'b1}});
    check_eq("rsp_vld", rsp_vld, 0);
    report_test(0, "reset state");

    begin_test();
    for (int i = 0; i < N_WR; i++)
      for (int c = 0; c < NUM_CH; c++)
      begin
        addrs[c][i] = {$random(seed)} % 128;
        write_reg(c, addrs[c][i], DATA_W'($random(seed)));
      end
    for (int i = 0; i < N_WR; i++)
      for (int c = 0; c < NUM_CH; c++)
        read_reg(c, addrs[c][i], KIND_OK);
    wait_drain();
    report_test(1, "write then read");

    begin_test();
    for (int i = 0; i < N_UNW; i++)
      for (int c = 0; c < NUM_CH; c++)
      begin
        addr = {$random(seed)} % 128;
        while (written[c][addr])
          addr = (addr + 1) % 128;
        read_reg(c, addr, KIND_OK);
      end
    wait_drain();
    report_test(2, "reset values and wire format");

    begin_test();
    ch = {$random(seed)} % NUM_CH;
    @(negedge clk);
    corrupt[ch] = 1'b1;
    read_reg(ch, addrs[ch][0], KIND_PAR);
    wait_drain();
    corrupt[ch] = 1'b0;
    read_reg(ch, addrs[ch][0], KIND_OK);
    read_reg(ch, addrs[ch][1], KIND_OK);
    wait_drain();
    report_test(3, "parity error");

    begin_test();
    ch = (ch + 1) % NUM_CH;
    drop[ch] = 1'b1;
    read_reg(ch, addrs[ch][2], KIND_TMO);
    wait_drain();
    drop[ch] = 1'b0;
    read_reg(ch, addrs[ch][2], KIND_OK);
    wait_drain();
    report_test(4, "response timeout");

    // both channels answer while the output register is blocked.
    begin_test();
    for (int r = 0; r < ROUNDS; r++)
    begin
      @(negedge clk);
      rsp_rdy = 1'b0;
      for (int c = 0; c < NUM_CH; c++)
        read_reg(c, {$random(seed)} % 128, KIND_OK);
      while (!rsp_vld)
        @(negedge clk);
      hold = HOLD_MIN + ({$random(seed)} % HOLD_SPAN);
      repeat (hold) @(negedge clk);
      check_eq("rsp_vld", rsp_vld, 1);
      cmd_ch = CH_W'((int'(rsp_ch) + 1) % NUM_CH);
      #1;
      check_true(!cmd_rdy, "cmd_rdy went high while the channel still held its response");
      @(negedge clk);
      rsp_rdy = 1'b1;
      wait_drain();
    end
    report_test(5, "concurrency and back-pressure");

    $display("checks passed %0d, failed %0d", n_pass, n_fail);
    if (n_fail == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== testbench/uart_slave_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_slave_model #(
  parameter int CH   = 0,
  parameter int SEED = 0
) (
  input  logic       clk,
  input  logic       rx,          // bridge uart_tx.
  input  logic       corrupt,     // flip the parity of the next answer.
  input  logic       drop,        // leave the next read unanswered.
  output logic       tx,
  output logic [7:0] frame_errs
);
  import uart_bridge_pkg::*;

  logic [DATA_W-1:0] regs [128];
  integer            seed;
  int                cyc = 0;

  always @(posedge clk)
    cyc <= cyc + 1;

  // samples every bit in the middle of its period, on falling edges.
  task automatic get_frame(output logic [DATA_W-1:0] data, output int start_cyc);
    logic [DATA_W+1:0] bits;    // data, parity, stop.
    begin
      do
        @(negedge clk);
      while (rx !== 1'b0);
      start_cyc = cyc;
      repeat (HALF_BIT - 1) @(negedge clk);
      if (rx !== 1'b0)
      begin
        $display("slave ch%0d: start bit did not stay low at %0t", CH, $time);
        frame_errs = frame_errs + 1'b1;
      end
      for (int i = 0; i < DATA_W + 2; i++)
      begin
        repeat (CLKS_PER_BIT) @(negedge clk);
        bits[i] = rx;
      end
      data = bits[DATA_W-1:0];
      if ((^bits[DATA_W:0]) !== 1'b1)
      begin
        $display("slave ch%0d: received frame has bad parity at %0t", CH, $time);
        frame_errs = frame_errs + 1'b1;
      end
      if (bits[DATA_W+1] !== 1'b1)
      begin
        $display("slave ch%0d: received frame has no stop bit at %0t", CH, $time);
        frame_errs = frame_errs + 1'b1;
      end
    end
  endtask

  task automatic put_frame(input logic [DATA_W-1:0] data, input logic bad_par);
    logic [FRAME_BITS-1:0] bits;
    begin
      bits = {1'b1, (~^data) ^ bad_par, data, 1'b0};
      for (int i = 0; i < FRAME_BITS; i++)
      begin
        tx = bits[i];
        repeat (CLKS_PER_BIT) @(negedge clk);
      end
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // register device
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  initial
  begin
    logic [DATA_W-1:0] first;
    logic [DATA_W-1:0] second;
    int                t_first;
    int                t_second;
    int                delay;
    seed       = SEED;
    tx         = 1'b1;
    frame_errs = '0;
    for (int a = 0; a < 128; a++)
      regs[a] = DATA_W'(a) ^ 8'h5A;
    forever
    begin
      get_frame(first, t_first);
      if (first[7])
      begin
        get_frame(second, t_second);
        if (t_second - t_first < FRAME_BITS * CLKS_PER_BIT + GAP_CYCLES)
        begin
          $display("slave ch%0d: write frames only %0d cycles apart at %0t",
                   CH, t_second - t_first, $time);
          frame_errs = frame_errs + 1'b1;
        end
        regs[first[6:0]] = second;
      end
      else if (!drop)
      begin
        delay = 20 + ({$random(seed)} % 181);  // 20 to 200 cycles.
        repeat (delay) @(negedge clk);
        put_frame(regs[first[6:0]], corrupt);
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/uart_bridge_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_bridge_top (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               cmd_vld,
  input  logic [uart_bridge_pkg::CH_W-1:0]   cmd_ch,
  input  logic [uart_bridge_pkg::CMD_W-1:0]  cmd_data,
  input  logic [uart_bridge_pkg::NUM_CH-1:0] uart_rx,
  input  logic                               rsp_rdy,
  output logic                               cmd_rdy,
  output logic [uart_bridge_pkg::NUM_CH-1:0] uart_tx,
  output logic                               rsp_vld,
  output logic [uart_bridge_pkg::CH_W-1:0]   rsp_ch,
  output logic [uart_bridge_pkg::DATA_W-1:0] rsp_data,
  output logic                               rsp_err
);
  import uart_bridge_pkg::*;

  logic [NUM_CH-1:0]             ch_vld;
  logic [NUM_CH-1:0]             ch_rdy;
  logic [CMD_W-1:0]              ch_cmd;
  logic [NUM_CH-1:0]             ch_rsp_vld;
  logic [NUM_CH-1:0]             ch_rsp_rdy;
  logic [NUM_CH-1:0][DATA_W-1:0] ch_rsp_data;
  logic [NUM_CH-1:0]             ch_rsp_err;

  cmd_dispatch u_cmd_dispatch (
    .clk      (clk),
    .rst_n    (rst_n),
    .cmd_vld  (cmd_vld),
    .cmd_ch   (cmd_ch),
    .cmd_data (cmd_data),
    .ch_rdy   (ch_rdy),
    .cmd_rdy  (cmd_rdy),
    .ch_vld   (ch_vld),
    .ch_cmd   (ch_cmd)
  );

  // one master per uart channel.
  for (genvar i = 0; i < NUM_CH; i++)
  begin : g_ch
    uart_cmd_master u_master (
      .clk         (clk),
      .rst_n       (rst_n),
      .ch_vld      (ch_vld[i]),
      .ch_cmd      (ch_cmd),
      .ch_rsp_rdy  (ch_rsp_rdy[i]),
      .uart_rx     (uart_rx[i]),
      .ch_rdy      (ch_rdy[i]),
      .uart_tx     (uart_tx[i]),
      .ch_rsp_vld  (ch_rsp_vld[i]),
      .ch_rsp_data (ch_rsp_data[i]),
      .ch_rsp_err  (ch_rsp_err[i])
    );
  end

  rsp_collect u_rsp_collect (
    .clk         (clk),
    .rst_n       (rst_n),
    .ch_rsp_vld  (ch_rsp_vld),
    .ch_rsp_data (ch_rsp_data),
    .ch_rsp_err  (ch_rsp_err),
    .rsp_rdy     (rsp_rdy),
    .ch_rsp_rdy  (ch_rsp_rdy),
    .rsp_vld     (rsp_vld),
    .rsp_ch      (rsp_ch),
    .rsp_data    (rsp_data),
    .rsp_err     (rsp_err)
  );

endmodule

`default_nettype wire

// ==== logic/rsp_collect.sv ====
`timescale 1ns/1ps
`default_nettype none

module rsp_collect (
  input  logic                                                     clk,
  input  logic                                                     rst_n,
  input  logic [uart_bridge_pkg::NUM_CH-1:0]                       ch_rsp_vld,
  input  logic [uart_bridge_pkg::NUM_CH-1:0][uart_bridge_pkg::DATA_W-1:0] ch_rsp_data,
  input  logic [uart_bridge_pkg::NUM_CH-1:0]                       ch_rsp_err,
  input  logic                                                     rsp_rdy,
  output logic [uart_bridge_pkg::NUM_CH-1:0]                       ch_rsp_rdy,
  output logic                                                     rsp_vld,
  output logic [uart_bridge_pkg::CH_W-1:0]                         rsp_ch,
  output logic [uart_bridge_pkg::DATA_W-1:0]                       rsp_data,
  output logic                                                     rsp_err
);
  import uart_bridge_pkg::*;

  logic [CH_W-1:0] last_q;
  logic [CH_W-1:0] sel;
  logic            found;
  logic            load;

  // first valid channel after the last grant.
  always_comb
  begin
    int idx;
    found = 1'b0;
    sel   = last_q;
    for (int k = 1; k <= NUM_CH; k++)
    begin
      idx = int'(last_q) + k;
      if (idx >= NUM_CH)
        idx = idx - NUM_CH;
      if (!found && ch_rsp_vld[idx])
      begin
        found = 1'b1;
        sel   = CH_W'(idx);
      end
    end
  end

  assign load = found && (!rsp_vld || rsp_rdy);  // empty or draining.

  always_comb
  begin
    for (int i = 0; i < NUM_CH; i++)
      ch_rsp_rdy[i] = load && (sel == CH_W'(i));
  end

  always_ff @(posedge clk)
  begin
    if (load)
    begin
      rsp_ch   <= sel;
      rsp_data <= ch_rsp_data[sel];
      rsp_err  <= ch_rsp_err[sel];
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rsp_vld <= 1'b0;
      last_q  <= CH_W'(NUM_CH - 1);  // channel 0 wins first.
    end
    else if (load)
    begin
      rsp_vld <= 1'b1;
      last_q  <= sel;
    end
    else if (rsp_rdy)
      rsp_vld <= 1'b0;
  end

endmodule

`default_nettype wire

// ==== logic/cmd_dispatch.sv ====
`timescale 1ns/1ps
`default_nettype none

module cmd_dispatch (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               cmd_vld,
  input  logic [uart_bridge_pkg::CH_W-1:0]   cmd_ch,
  input  logic [uart_bridge_pkg::CMD_W-1:0]  cmd_data,
  input  logic [uart_bridge_pkg::NUM_CH-1:0] ch_rdy,
  output logic                               cmd_rdy,
  output logic [uart_bridge_pkg::NUM_CH-1:0] ch_vld,
  output logic [uart_bridge_pkg::CMD_W-1:0]  ch_cmd
);
  import uart_bridge_pkg::*;

  assign ch_cmd  = cmd_data;  // every master sees the word.
  assign cmd_rdy = ch_rdy[cmd_ch];

  always_comb
  begin
    for (int i = 0; i < NUM_CH; i++)
      ch_vld[i] = cmd_vld && (cmd_ch == CH_W'(i));
  end

endmodule

`default_nettype wire

// ==== uart_master/uart_cmd_master.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_cmd_master (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               ch_vld,
  input  logic [uart_bridge_pkg::CMD_W-1:0]  ch_cmd,
  input  logic                               ch_rsp_rdy,
  input  logic                               uart_rx,
  output logic                               ch_rdy,
  output logic                               uart_tx,
  output logic                               ch_rsp_vld,
  output logic [uart_bridge_pkg::DATA_W-1:0] ch_rsp_data,
  output logic                               ch_rsp_err
);
  import uart_bridge_pkg::*;

  typedef enum logic [2:0] {M_IDLE, M_TX1, M_GAP, M_TX2, M_RX, M_RSP} m_state_t;

  m_state_t          state;
  logic [CMD_W-1:0]  cmd_q;
  logic [GAP_W-1:0]  gap_cnt;
  logic              gap_last;
  logic              accept;
  logic              tx_send;
  logic [DATA_W-1:0] tx_byte;
  logic              tx_busy;
  logic              tx_done;
  logic              rx_arm;
  logic [DATA_W-1:0] rx_byte;
  logic              rx_valid;
  logic              rx_err;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // handshakes and frame requests
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign ch_rdy     = (state == M_IDLE) && !tx_busy;
  assign accept     = ch_vld && ch_rdy;
  assign ch_rsp_vld = (state == M_RSP);
  assign gap_last   = (gap_cnt == GAP_W'(GAP_CYCLES - 1));

  // first frame straight from the bus, the second from the held command.
  assign tx_send = accept || ((state == M_GAP) && gap_last);
  assign tx_byte = (state == M_IDLE) ? ch_cmd[CMD_W-1 -: DATA_W] : cmd_q[DATA_W-1:0];
  assign rx_arm  = (state == M_TX1) && tx_done && !cmd_q[WR_BIT];

  uart_tx_frame u_tx (
    .clk     (clk),
    .rst_n   (rst_n),
    .send    (tx_send),
    .byte_in (tx_byte),
    .tx      (uart_tx),
    .busy    (tx_busy),
    .done    (tx_done)
  );

  uart_rx_frame u_rx (
    .clk      (clk),
    .rst_n    (rst_n),
    .arm      (rx_arm),
    .rx       (uart_rx),
    .byte_out (rx_byte),
    .valid    (rx_valid),
    .err      (rx_err)
  );

  always_ff @(posedge clk)
  begin
    if (accept)
      cmd_q <= ch_cmd;
    if ((state == M_RX) && rx_valid)
    begin
      ch_rsp_data <= rx_byte;
      ch_rsp_err  <= rx_err;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state   <= M_IDLE;
      gap_cnt <= '0;
    end
    else
    begin
      case (state)
        M_IDLE:
          if (accept)
            state <= M_TX1;
        M_TX1:
        begin
          gap_cnt <= '0;
          if (tx_done)
            state <= cmd_q[WR_BIT] ? M_GAP : M_RX;
        end
        M_GAP:
        begin
          gap_cnt <= gap_cnt + 1'b1;
          if (gap_last)
            state <= M_TX2;
        end
        M_TX2:
          if (tx_done)
            state <= M_IDLE;
        M_RX:
          if (rx_valid)
            state <= M_RSP;
        default:
          if (ch_rsp_rdy)
            state <= M_IDLE;  // response taken.
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== uart_master/uart_rx_frame.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_rx_frame (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               arm,
  input  logic                               rx,
  output logic [uart_bridge_pkg::DATA_W-1:0] byte_out,
  output logic                               valid,
  output logic                               err
);
  import uart_bridge_pkg::*;

  typedef enum logic [1:0] {S_IDLE, S_WAIT, S_START, S_RECV} rx_state_t;

  rx_state_t            state;
  logic                 rx_meta;
  logic                 rx_sync;
  logic                 rx_prev;
  logic                 fall;
  logic [BIT_CNT_W-1:0] bit_cnt;
  logic [BIT_IDX_W-1:0] bit_idx;
  logic [TMO_W-1:0]     tmo_cnt;
  logic [DATA_W-1:0]    data_sr;
  logic                 par_bit;
  logic                 sample;
  logic                 frame_end;
  logic                 timeout;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end
    else
    begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  assign fall      = rx_prev && !rx_sync;
  assign sample    = (state == S_RECV) && (bit_cnt == BIT_CNT_W'(CLKS_PER_BIT - 1));
  assign frame_end = sample && (bit_idx == BIT_IDX_W'(FRAME_BITS - 1));
  assign timeout   = (state == S_WAIT) && !fall && (tmo_cnt == TMO_W'(RSP_TIMEOUT - 1));

  // bit index 1..8 is data, 9 parity, 10 stop.
  always_ff @(posedge clk)
  begin
    if (sample && (bit_idx <= BIT_IDX_W'(DATA_W)))
      data_sr <= {rx_sync, data_sr[DATA_W-1:1]};
    if (sample && (bit_idx == BIT_IDX_W'(DATA_W + 1)))
      par_bit <= rx_sync;
    if (frame_end)
      byte_out <= data_sr;
    else if (timeout)
      byte_out <= '0;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state   <= S_IDLE;
      bit_cnt <= '0;
      bit_idx <= '0;
      tmo_cnt <= '0;
      valid   <= 1'b0;
      err     <= 1'b0;
    end
    else
    begin
      valid <= 1'b0;
      case (state)
        S_IDLE:
        begin
          tmo_cnt <= '0;
          if (arm)
            state <= S_WAIT;
        end
        S_WAIT:
        begin
          bit_cnt <= '0;
          if (fall)
            state <= S_START;
          else if (timeout)
          begin
            state <= S_IDLE;
            valid <= 1'b1;
            err   <= 1'b1;
          end
          else
            tmo_cnt <= tmo_cnt + 1'b1;
        end
        S_START:
        begin
          if (bit_cnt == BIT_CNT_W'(HALF_BIT - 1))
          begin
            bit_cnt <= '0;
            bit_idx <= BIT_IDX_W'(1);
            state   <= rx_sync ? S_WAIT : S_RECV;  // a glitch goes back to waiting.
          end
          else
            bit_cnt <= bit_cnt + 1'b1;
        end
        default:
        begin
          if (sample)
          begin
            bit_cnt <= '0;
            bit_idx <= bit_idx + 1'b1;
            if (frame_end)
            begin
              state <= S_IDLE;
              valid <= 1'b1;
              err   <= !(^{data_sr, par_bit}) || !rx_sync;
            end
          end
          else
            bit_cnt <= bit_cnt + 1'b1;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== uart_master/uart_tx_frame.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_tx_frame (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               send,
  input  logic [uart_bridge_pkg::DATA_W-1:0] byte_in,
  output logic                               tx,
  output logic                               busy,
  output logic                               done
);
  import uart_bridge_pkg::*;

  logic [FRAME_BITS-2:0] shreg;    // data, parity and stop still to go.
  logic [BIT_CNT_W-1:0]  bit_cnt;
  logic [BIT_IDX_W-1:0]  bit_idx;
  logic                  bit_end;
  logic                  last_bit;

  assign bit_end  = (bit_cnt == BIT_CNT_W'(CLKS_PER_BIT - 1));
  assign last_bit = (bit_idx == BIT_IDX_W'(FRAME_BITS - 1));
  assign done     = busy && bit_end && last_bit; // last cycle of the stop bit.

  // odd parity, stop bit on top, shifted out lsb first.
  always_ff @(posedge clk)
  begin
    if (!busy && send)
    begin
      shreg <= {1'b1, ~^byte_in, byte_in};
    end
    else if (busy && bit_end)
    begin
      shreg <= {1'b1, shreg[FRAME_BITS-2:1]};
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy    <= 1'b0;
      tx      <= 1'b1;
      bit_cnt <= '0;
      bit_idx <= '0;
    end
    else if (!busy)
    begin
      if (send)
      begin
        busy    <= 1'b1;
        tx      <= 1'b0;  // start bit.
        bit_cnt <= '0;
        bit_idx <= '0;
      end
    end
    else if (bit_end)
    begin
      bit_cnt <= '0;
      if (last_bit)
      begin
        busy <= 1'b0;
        tx   <= 1'b1;
      end
      else
      begin
        bit_idx <= bit_idx + 1'b1;
        tx      <= shreg[0];
      end
    end
    else
    begin
      bit_cnt <= bit_cnt + 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== common/uart_bridge_pkg.sv ====
`default_nettype none

package uart_bridge_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // bridge shape
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int NUM_CH    = 2;
  localparam int CH_W      = 1;
  localparam int CMD_W     = 16;
  localparam int DATA_W    = 8;
  localparam int WR_BIT    = 15;  // write flag inside a command.
  localparam int ACC_CNT_W = 4;   // per channel accepted command count.

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // uart framing
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int CLKS_PER_BIT = 16;  // 434 on the board at 50 MHz.
  localparam int BIT_CNT_W    = 5;
  localparam int HALF_BIT     = CLKS_PER_BIT / 2;
  localparam int FRAME_BITS   = DATA_W + 3;  // start, data, parity, stop.
  localparam int BIT_IDX_W    = 4;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // command timing
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int GAP_CYCLES  = 100;
  localparam int GAP_W       = $clog2(GAP_CYCLES);
  localparam int RSP_TIMEOUT = 4000;
  localparam int TMO_W       = $clog2(RSP_TIMEOUT);

endpackage

`default_nettype wire
